// ==== design/exec_combine.sv ====
`timescale 1ns/1ps

module exec_combine (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 in_valid,
    output logic                 in_ready,
    input  exec_pkg::op_type_t   op_type,
    input  exec_pkg::funct3_t    funct3,
    input  exec_pkg::reg_addr_t  rd,
    input  exec_pkg::word_t      store_value,
    input  exec_pkg::word_t      sum,
    input  exec_pkg::word_t      alu_value,
    input  logic                 taken,
    input  exec_pkg::word_t      target,
    input  exec_pkg::word_t      link,
    input  logic                 mispredict,
    output logic                 result_valid,
    input  logic                 result_ready,
    output exec_pkg::reg_addr_t  result_rd,
    output exec_pkg::word_t      result_value,
    output logic                 mem_valid,
    input  logic                 mem_ready,
    output logic                 mem_read,
    output exec_pkg::byte_mask_t mem_write_mask,
    output exec_pkg::word_t      mem_addr,
    output exec_pkg::word_t      mem_wdata,
    output exec_pkg::reg_addr_t  mem_rd,
    output exec_pkg::funct3_t    mem_funct3,
    output logic                 jump_valid,
    input  logic                 jump_ready,
    output logic                 jump_taken,
    output exec_pkg::word_t      jump_target,
    output logic                 jump_mispredict
);

    logic                 transfer;
    logic                 produce_result;
    logic                 produce_mem;
    logic                 produce_jump;
    exec_pkg::word_t      next_result_value;
    logic                 next_mem_read;
    exec_pkg::byte_mask_t next_mem_mask;
    exec_pkg::word_t      next_mem_wdata;
    logic [1:0]           offset;
    exec_pkg::byte_mask_t store_mask;
    exec_pkg::word_t      store_data;

    // accept only when no channel would overflow, whatever the operation needs
    assign in_ready = (!result_valid || result_ready)
                   && (!mem_valid || mem_ready)
                   && (!jump_valid || jump_ready);
    assign transfer = in_valid && in_ready;

    assign offset = sum[1:0];

    // shift the store data into its byte lanes
    always_comb begin
        case (funct3)
            exec_pkg::F3_B: begin
                store_data = {24'b0, store_value[7:0]} << {offset, 3'b000};
                store_mask = 4'b0001 << offset;
            end
            exec_pkg::F3_H: begin
                store_data = offset[1] ? {store_value[15:0], 16'b0} : {16'b0, store_value[15:0]};
                store_mask = offset[1] ? 4'b1100 : 4'b0011;
            end
            exec_pkg::F3_W: begin
                store_data = store_value;
                store_mask = 4'b1111;
            end
            default: begin
                store_data = store_value;
                store_mask = 4'b0000;   // no legal store size, nothing written
            end
        endcase
    end

    always_comb begin
        produce_result = 1'b0;
        produce_mem = 1'b0;
        produce_jump = 1'b0;
        next_result_value = alu_value;
        next_mem_read = 1'b0;
        next_mem_mask = 4'b0000;
        next_mem_wdata = '0;
        case (op_type)
            exec_pkg::OP_ALU: begin
                produce_result = 1'b1;
            end
            exec_pkg::OP_LOAD: begin
                produce_mem = 1'b1;
                next_mem_read = 1'b1;
            end
            exec_pkg::OP_STORE: begin
                produce_mem = 1'b1;
                next_mem_mask = store_mask;
                next_mem_wdata = store_data;
            end
            exec_pkg::OP_BRANCH: begin
                produce_jump = 1'b1;
            end
            exec_pkg::OP_JUMP: begin
                produce_jump = 1'b1;
                produce_result = rd != '0;   // x0 never takes the link
                next_result_value = link;
            end
            default: begin
                produce_result = 1'b0;
            end
        endcase
    end

    // a channel fills on transfer and drains on its own ready
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            result_valid <= 1'b0;
            mem_valid <= 1'b0;
            jump_valid <= 1'b0;
        end else begin
            if (transfer && produce_result) begin
                result_valid <= 1'b1;
            end else if (result_ready) begin
                result_valid <= 1'b0;
            end
            if (transfer && produce_mem) begin
                mem_valid <= 1'b1;
            end else if (mem_ready) begin
                mem_valid <= 1'b0;
            end
            if (transfer && produce_jump) begin
                jump_valid <= 1'b1;
            end else if (jump_ready) begin
                jump_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (transfer && produce_result) begin
            result_rd <= rd;
            result_value <= next_result_value;
        end
        if (transfer && produce_mem) begin
            mem_read <= next_mem_read;
            mem_write_mask <= next_mem_mask;
            mem_addr <= sum;
            mem_wdata <= next_mem_wdata;
            mem_rd <= rd;
            mem_funct3 <= funct3;   // load-align needs size and sign
        end
        if (transfer && produce_jump) begin
            jump_taken <= taken;
            jump_target <= target;
            jump_mispredict <= mispredict;
        end
    end

endmodule

// ==== design/exec_flow_unit.sv ====
`timescale 1ns/1ps

module exec_flow_unit (
    input  exec_pkg::op_type_t op_type,
    input  exec_pkg::funct3_t  funct3,
    input  exec_pkg::word_t    rs1_value,
    input  exec_pkg::word_t    rs2_value,
    input  exec_pkg::word_t    imm,
    input  exec_pkg::word_t    pc,
    input  exec_pkg::word_t    predicted_pc,
    input  exec_pkg::word_t    jump_base,
    output logic               taken,
    output exec_pkg::word_t    target,
    output exec_pkg::word_t    link,
    output logic               mispredict
);

    exec_pkg::word_t seq_pc;
    logic            branch_cond;

    assign seq_pc = pc + 32'd4;
    assign link = seq_pc;   // return address for jal and jalr

    always_comb begin
        case (funct3)
            exec_pkg::F3_BEQ:  branch_cond = rs1_value == rs2_value;
            exec_pkg::F3_BNE:  branch_cond = rs1_value != rs2_value;
            exec_pkg::F3_BLT:  branch_cond = $signed(rs1_value) < $signed(rs2_value);
            exec_pkg::F3_BGE:  branch_cond = $signed(rs1_value) >= $signed(rs2_value);
            exec_pkg::F3_BLTU: branch_cond = rs1_value < rs2_value;
            exec_pkg::F3_BGEU: branch_cond = rs1_value >= rs2_value;
            default:           branch_cond = 1'b0;   // codes 2 and 3 are not branches
        endcase
    end

    always_comb begin
        taken = 1'b0;
        target = seq_pc;
        case (op_type)
            exec_pkg::OP_BRANCH: begin
                taken = branch_cond;
                target = branch_cond ? pc + imm : seq_pc;
            end
            exec_pkg::OP_JUMP: begin
                taken = 1'b1;
                target = jump_base + imm;   // base is pc for jal and rs1 for jalr
            end
            default: begin
                taken = 1'b0;
            end
        endcase
    end

    // fetch has to redirect whenever its guess differs from the real next pc
    assign mispredict = target != predicted_pc;

endmodule

// ==== design/exec_int_unit.sv ====
`timescale 1ns/1ps

module exec_int_unit (
    input  exec_pkg::funct3_t funct3,
    input  logic              alt,
    input  exec_pkg::word_t   rs1_value,
    input  exec_pkg::word_t   rs2_value,
    output exec_pkg::word_t   sum,
    output exec_pkg::word_t   alu_value
);

    logic [4:0]         shamt;
    exec_pkg::word_t    difference;
    exec_pkg::word_t    shift_left;
    exec_pkg::word_t    shift_logical;
    logic signed [31:0] shift_arith;
    exec_pkg::word_t    shift_right;
    logic               less_signed;
    logic               less_unsigned;

    // the adder also feeds load and store addresses
    assign sum = rs1_value + rs2_value;
    assign difference = rs1_value - rs2_value;

    assign shamt = rs2_value[4:0];   // only the low five bits count on RV32
    assign shift_left = rs1_value << shamt;
    assign shift_logical = rs1_value >> shamt;
    assign shift_arith = $signed(rs1_value) >>> shamt;   // kept in its own signed net
    assign shift_right = alt ? exec_pkg::word_t'(shift_arith) : shift_logical;

    assign less_signed = $signed(rs1_value) < $signed(rs2_value);
    assign less_unsigned = rs1_value < rs2_value;

    always_comb begin
        case (funct3)
            exec_pkg::F3_ADD_SUB: begin
                alu_value = alt ? difference : sum;
            end
            exec_pkg::F3_SLL: begin
                alu_value = shift_left;
            end
            exec_pkg::F3_SLT: begin
                alu_value = {31'b0, less_signed};
            end
            exec_pkg::F3_SLTU: begin
                alu_value = {31'b0, less_unsigned};
            end
            exec_pkg::F3_XOR: begin
                alu_value = rs1_value ^ rs2_value;
            end
            exec_pkg::F3_SRL_SRA: begin
                alu_value = shift_right;
            end
            exec_pkg::F3_OR: begin
                alu_value = rs1_value | rs2_value;
            end
            exec_pkg::F3_AND: begin
                alu_value = rs1_value & rs2_value;
            end
            default: begin
                alu_value = sum;
            end
        endcase
    end

endmodule

// ==== design/exec_pkg.sv ====
package exec_pkg;

    // data path and register file widths for RV32I
    typedef logic [31:0] word_t;         // operand, result, address or pc
    typedef logic [4:0]  reg_addr_t;     // destination register index
    typedef logic [2:0]  funct3_t;       // funct3 field of the instruction
    typedef logic [3:0]  byte_mask_t;    // one enable per byte lane

    // operation classes as sorted by the decoder
    typedef enum logic [2:0] {
        OP_ALU    = 3'd0,
        OP_LOAD   = 3'd1,
        OP_STORE  = 3'd2,
        OP_BRANCH = 3'd3,
        OP_JUMP   = 3'd4
    } op_type_t;

    // register and immediate arithmetic
    localparam funct3_t F3_ADD_SUB = 3'b000;   // alt selects sub
    localparam funct3_t F3_SLL     = 3'b001;
    localparam funct3_t F3_SLT     = 3'b010;
    localparam funct3_t F3_SLTU    = 3'b011;
    localparam funct3_t F3_XOR     = 3'b100;
    localparam funct3_t F3_SRL_SRA = 3'b101;   // alt selects sra
    localparam funct3_t F3_OR      = 3'b110;
    localparam funct3_t F3_AND     = 3'b111;

    // conditional branches
    localparam funct3_t F3_BEQ  = 3'b000;
    localparam funct3_t F3_BNE  = 3'b001;
    localparam funct3_t F3_BLT  = 3'b100;
    localparam funct3_t F3_BGE  = 3'b101;
    localparam funct3_t F3_BLTU = 3'b110;
    localparam funct3_t F3_BGEU = 3'b111;

    // store sizes, loads reuse these codes plus the unsigned variants
    localparam funct3_t F3_B = 3'b000;
    localparam funct3_t F3_H = 3'b001;
    localparam funct3_t F3_W = 3'b010;

endpackage

// ==== design/exec_stage.sv ====
`timescale 1ns/1ps

module exec_stage (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 in_valid,
    output logic                 in_ready,
    input  exec_pkg::op_type_t   op_type,
    input  exec_pkg::funct3_t    funct3,
    input  logic                 alt,
    input  exec_pkg::reg_addr_t  rd,
    input  exec_pkg::word_t      rs1_value,
    input  exec_pkg::word_t      rs2_value,   // already holds the immediate for I, load, store
    input  exec_pkg::word_t      store_value,
    input  exec_pkg::word_t      imm,
    input  exec_pkg::word_t      pc,
    input  exec_pkg::word_t      predicted_pc,
    input  exec_pkg::word_t      jump_base,
    output logic                 result_valid,
    input  logic                 result_ready,
    output exec_pkg::reg_addr_t  result_rd,
    output exec_pkg::word_t      result_value,
    output logic                 mem_valid,
    input  logic                 mem_ready,
    output logic                 mem_read,
    output exec_pkg::byte_mask_t mem_write_mask,
    output exec_pkg::word_t      mem_addr,
    output exec_pkg::word_t      mem_wdata,
    output exec_pkg::reg_addr_t  mem_rd,
    output exec_pkg::funct3_t    mem_funct3,
    output logic                 jump_valid,
    input  logic                 jump_ready,
    output logic                 jump_taken,
    output exec_pkg::word_t      jump_target,
    output logic                 jump_mispredict
);

    exec_pkg::word_t sum;
    exec_pkg::word_t alu_value;
    logic            taken;
    exec_pkg::word_t target;
    exec_pkg::word_t link;
    logic            mispredict;

    exec_int_unit i_exec_int_unit (
        .funct3, .alt, .rs1_value, .rs2_value,
        .sum, .alu_value
    );

    exec_flow_unit i_exec_flow_unit (
        .op_type, .funct3, .rs1_value, .rs2_value,
        .imm, .pc, .predicted_pc, .jump_base,
        .taken, .target, .link, .mispredict
    );

    exec_combine i_exec_combine (
        .clk, .arst_n,
        .in_valid, .in_ready,
        .op_type, .funct3, .rd, .store_value,
        .sum, .alu_value,
        .taken, .target, .link, .mispredict,
        .result_valid, .result_ready, .result_rd, .result_value,
        .mem_valid, .mem_ready, .mem_read, .mem_write_mask,
        .mem_addr, .mem_wdata, .mem_rd, .mem_funct3,
        .jump_valid, .jump_ready, .jump_taken, .jump_target, .jump_mispredict
    );

endmodule

// ==== exec_stage.f ====
design/exec_pkg.sv
design/exec_int_unit.sv
design/exec_flow_unit.sv
design/exec_combine.sv
design/exec_stage.sv
test/exec_stage_assertions.sv
test/exec_stage_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the execute stage testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module exec_stage_tb \
    -f exec_stage.f -o exec_stage_sim \
    && ./obj_dir/exec_stage_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "TEST OK" sim.log && echo "simulation passed" && exit 0 \
    || { echo "simulation failed"; exit 1; }

// ==== test/exec_stage_assertions.sv ====
`timescale 1ns/1ps

module exec_stage_assertions (
    input logic                 clk,
    input logic                 arst_n,
    input logic                 result_valid,
    input logic                 result_ready,
    input exec_pkg::reg_addr_t  result_rd,
    input exec_pkg::word_t      result_value,
    input logic                 mem_valid,
    input logic                 mem_ready,
    input logic                 mem_read,
    input exec_pkg::byte_mask_t mem_write_mask,
    input exec_pkg::word_t      mem_addr,
    input exec_pkg::word_t      mem_wdata,
    input exec_pkg::reg_addr_t  mem_rd,
    input exec_pkg::funct3_t    mem_funct3,
    input logic                 jump_valid,
    input logic                 jump_ready,
    input logic                 jump_taken,
    input exec_pkg::word_t      jump_target,
    input logic                 jump_mispredict
);

    assert property (@(posedge clk) !arst_n |=> !result_valid && !mem_valid && !jump_valid)
        else $error("a valid is high right after reset");

    assert property (@(posedge clk) disable iff (!arst_n) result_valid && !result_ready
        |=> result_valid && $stable(result_rd) && $stable(result_value))
        else $error("result channel changed while stalled");

    assert property (@(posedge clk) disable iff (!arst_n) mem_valid && !mem_ready
        |=> mem_valid && $stable(mem_read) && $stable(mem_write_mask) && $stable(mem_addr)
            && $stable(mem_wdata) && $stable(mem_rd) && $stable(mem_funct3))
        else $error("mem channel changed while stalled");

    assert property (@(posedge clk) disable iff (!arst_n) jump_valid && !jump_ready
        |=> jump_valid && $stable(jump_taken) && $stable(jump_target) && $stable(jump_mispredict))
        else $error("jump channel changed while stalled");

    // a load never carries byte enables
    assert property (@(posedge clk) disable iff (!arst_n)
        mem_valid |-> !(mem_read && mem_write_mask != 4'b0000))
        else $error("load request with a write mask");

endmodule

bind exec_combine exec_stage_assertions i_exec_stage_assertions (.*);

// ==== test/exec_stage_tb.sv ====
`timescale 1ns/1ps

module exec_stage_tb;

    localparam int NUM_OPS = 400;
    localparam int TIMEOUT_CYCLES = 20 * NUM_OPS;

    typedef struct packed {
        logic [31:0]         stamp;
        exec_pkg::reg_addr_t rd;
        exec_pkg::word_t     value;
    } result_item_t;

    typedef struct packed {
        logic [31:0]          stamp;
        logic                 read;
        exec_pkg::byte_mask_t mask;
        exec_pkg::word_t      addr;
        exec_pkg::word_t      wdata;
        exec_pkg::reg_addr_t  rd;
        exec_pkg::funct3_t    funct3;
    } mem_item_t;

    typedef struct packed {
        logic [31:0]     stamp;
        logic            taken;
        exec_pkg::word_t target;
        logic            mispredict;
    } jump_item_t;

    logic                 clk;
    logic                 arst_n;
    logic                 in_valid;
    logic                 in_ready;
    exec_pkg::op_type_t   op_type;
    exec_pkg::funct3_t    funct3;
    logic                 alt;
    exec_pkg::reg_addr_t  rd;
    exec_pkg::word_t      rs1_value;
    exec_pkg::word_t      rs2_value;
    exec_pkg::word_t      store_value;
    exec_pkg::word_t      imm;
    exec_pkg::word_t      pc;
    exec_pkg::word_t      predicted_pc;
    exec_pkg::word_t      jump_base;
    logic                 result_valid;
    logic                 result_ready;
    exec_pkg::reg_addr_t  result_rd;
    exec_pkg::word_t      result_value;
    logic                 mem_valid;
    logic                 mem_ready;
    logic                 mem_read;
    exec_pkg::byte_mask_t mem_write_mask;
    exec_pkg::word_t      mem_addr;
    exec_pkg::word_t      mem_wdata;
    exec_pkg::reg_addr_t  mem_rd;
    exec_pkg::funct3_t    mem_funct3;
    logic                 jump_valid;
    logic                 jump_ready;
    logic                 jump_taken;
    exec_pkg::word_t      jump_target;
    logic                 jump_mispredict;

    integer       seed = 32'hf066_380d;
    logic [31:0]  cycle = 32'd0;
    int           accepted_count = 0;
    logic         accepted_last = 1'b0;
    logic         result_seen = 1'b0;
    logic         mem_seen = 1'b0;
    logic         jump_seen = 1'b0;
    result_item_t result_q[$];
    mem_item_t    mem_q[$];
    jump_item_t   jump_q[$];

    exec_stage i_exec_stage (.*);

    always begin
        #4 clk = ~clk;
    end

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Error: %s is 0x%08h, expected 0x%08h", name, actual, expected);
            stop_with_failure("output value mismatch");
        end
    endtask

    // expected outputs on every channel for one operation
    function automatic void ref_exec(
        input exec_pkg::op_type_t op, input exec_pkg::funct3_t f3, input logic a,
        input exec_pkg::reg_addr_t d, input exec_pkg::word_t x, input exec_pkg::word_t y,
        input exec_pkg::word_t sv, input exec_pkg::word_t im, input exec_pkg::word_t p,
        input exec_pkg::word_t pred, input exec_pkg::word_t base,
        output logic has_result, output result_item_t r,
        output logic has_mem, output mem_item_t m,
        output logic has_jump, output jump_item_t j);
        logic signed [31:0] sx;
        exec_pkg::word_t    addr;
        logic               cond;
        sx = x;
        addr = x + y;
        has_result = 1'b0;
        has_mem = 1'b0;
        has_jump = 1'b0;
        r = '0;
        m = '0;
        j = '0;
        r.rd = d;
        m.rd = d;
        m.funct3 = f3;
        m.addr = addr;
        case (f3)
            exec_pkg::F3_ADD_SUB: r.value = a ? x - y : addr;
            exec_pkg::F3_SLL:     r.value = x << y[4:0];
            exec_pkg::F3_SLT:     r.value = {31'b0, $signed(x) < $signed(y)};
            exec_pkg::F3_SLTU:    r.value = {31'b0, x < y};
            exec_pkg::F3_XOR:     r.value = x ^ y;
            exec_pkg::F3_SRL_SRA: begin
                sx = sx >>> y[4:0];
                r.value = a ? exec_pkg::word_t'(sx) : x >> y[4:0];
            end
            exec_pkg::F3_OR:      r.value = x | y;
            default:              r.value = x & y;
        endcase
        case (f3)
            exec_pkg::F3_BEQ:  cond = x == y;
            exec_pkg::F3_BNE:  cond = x != y;
            exec_pkg::F3_BLT:  cond = $signed(x) < $signed(y);
            exec_pkg::F3_BGE:  cond = $signed(x) >= $signed(y);
            exec_pkg::F3_BLTU: cond = x < y;
            exec_pkg::F3_BGEU: cond = x >= y;
            default:           cond = 1'b0;
        endcase
        if (op == exec_pkg::OP_ALU) begin
            has_result = 1'b1;
        end else if (op == exec_pkg::OP_LOAD) begin
            has_mem = 1'b1;
            m.read = 1'b1;
        end else if (op == exec_pkg::OP_STORE) begin
            has_mem = 1'b1;
            if (f3 == exec_pkg::F3_B) begin
                m.wdata = (sv & 32'h0000_00ff) << (8 * addr[1:0]);
                m.mask = 4'b0001 << addr[1:0];
            end else if (f3 == exec_pkg::F3_H) begin
                m.wdata = addr[1] ? sv << 16 : sv & 32'h0000_ffff;
                m.mask = addr[1] ? 4'b1100 : 4'b0011;
            end else begin
                m.wdata = sv;
                m.mask = 4'b1111;
            end
        end else begin
            has_jump = 1'b1;
            j.taken = (op == exec_pkg::OP_JUMP) ? 1'b1 : cond;
            j.target = (op == exec_pkg::OP_JUMP) ? base + im : (cond ? p + im : p + 32'd4);
            j.mispredict = j.target != pred;
            has_result = (op == exec_pkg::OP_JUMP) && (d != 5'd0);
            r.value = p + 32'd4;
        end
    endfunction

    // mostly small signed values so that compares hit equal and both signs
    function automatic exec_pkg::word_t pick_operand();
        logic [31:0] r;
        r = $random(seed);
        if (r[31:30] != 2'b00) begin
            return {{29{r[5]}}, r[4:2]};
        end
        return $random(seed);
    endfunction

    task automatic make_operation();
        logic [31:0] r;
        r = $random(seed);
        op_type = exec_pkg::op_type_t'(3'(r[15:0] % 16'd5));
        alt = r[16];
        rd = r[21:17];
        if (op_type == exec_pkg::OP_STORE) begin
            funct3 = 3'(r[29:28] % 2'd3);   // byte, half or word
        end else if (op_type == exec_pkg::OP_BRANCH) begin
            funct3 = r[24] ? {1'b1, r[23:22]} : {2'b00, r[22]};
        end else begin
            funct3 = r[24:22];
        end
        rs1_value = pick_operand();
        rs2_value = pick_operand();
        store_value = $random(seed);
        imm = {{20{r[31]}}, r[30:25], 6'b0};
        pc = {$random(seed)} & 32'hffff_fffc;
        jump_base = r[26] ? rs1_value : pc;
        r = $random(seed);
        if (r[1:0] == 2'b00) begin
            predicted_pc = $random(seed);
        end else if (r[1:0] == 2'b01) begin
            predicted_pc = pc + imm;
        end else begin
            predicted_pc = pc + 32'd4;
        end
    endtask

    always @(negedge clk) begin
        logic [31:0] r;
        if (arst_n) begin
            r = $random(seed);
            result_ready = r[0];
            mem_ready = r[1];
            jump_ready = r[2];
            if (!in_valid || accepted_last) begin
                if (accepted_count < NUM_OPS) begin
                    make_operation();
                    in_valid = r[3];
                end else begin
                    in_valid = 1'b0;
                end
            end
        end
    end

    always @(posedge clk) begin
        logic         has_result;
        logic         has_mem;
        logic         has_jump;
        logic         ready_expected;
        result_item_t er;
        mem_item_t    em;
        jump_item_t   ej;
        accepted_last = 1'b0;
        if (arst_n) begin
            // each channel holds at most one item, so a waiting item means a full register
            ready_expected = (result_q.size() == 0 || result_ready)
                          && (mem_q.size() == 0 || mem_ready)
                          && (jump_q.size() == 0 || jump_ready);
            check_value("in_ready", {31'b0, in_ready}, {31'b0, ready_expected});
            if (result_valid) begin
                if (result_q.size() == 0) begin
                    stop_with_failure("result channel delivered an item that was never sent");
                end
                if (!result_seen) begin
                    check_value("result_valid cycle", cycle, result_q[0].stamp + 32'd1);
                    result_seen = 1'b1;
                end
                if (result_ready) begin
                    er = result_q.pop_front();
                    check_value("result_rd", {27'b0, result_rd}, {27'b0, er.rd});
                    check_value("result_value", result_value, er.value);
                    result_seen = 1'b0;
                end
            end
            if (mem_valid) begin
                if (mem_q.size() == 0) begin
                    stop_with_failure("mem channel delivered an item that was never sent");
                end
                if (!mem_seen) begin
                    check_value("mem_valid cycle", cycle, mem_q[0].stamp + 32'd1);
                    mem_seen = 1'b1;
                end
                if (mem_ready) begin
                    em = mem_q.pop_front();
                    check_value("mem_read", {31'b0, mem_read}, {31'b0, em.read});
                    check_value("mem_write_mask", {28'b0, mem_write_mask}, {28'b0, em.mask});
                    check_value("mem_addr", mem_addr, em.addr);
                    check_value("mem_wdata", mem_wdata, em.wdata);
                    check_value("mem_rd", {27'b0, mem_rd}, {27'b0, em.rd});
                    check_value("mem_funct3", {29'b0, mem_funct3}, {29'b0, em.funct3});
                    mem_seen = 1'b0;
                end
            end
            if (jump_valid) begin
                if (jump_q.size() == 0) begin
                    stop_with_failure("jump channel delivered an item that was never sent");
                end
                if (!jump_seen) begin
                    check_value("jump_valid cycle", cycle, jump_q[0].stamp + 32'd1);
                    jump_seen = 1'b1;
                end
                if (jump_ready) begin
                    ej = jump_q.pop_front();
                    check_value("jump_taken", {31'b0, jump_taken}, {31'b0, ej.taken});
                    check_value("jump_target", jump_target, ej.target);
                    check_value("jump_mispredict", {31'b0, jump_mispredict},
                                {31'b0, ej.mispredict});
                    jump_seen = 1'b0;
                end
            end
            if (in_valid && in_ready) begin
                ref_exec(op_type, funct3, alt, rd, rs1_value, rs2_value, store_value, imm, pc,
                         predicted_pc, jump_base, has_result, er, has_mem, em, has_jump, ej);
                er.stamp = cycle;
                em.stamp = cycle;
                ej.stamp = cycle;
                if (has_result) result_q.push_back(er);
                if (has_mem) mem_q.push_back(em);
                if (has_jump) jump_q.push_back(ej);
                accepted_count = accepted_count + 1;
                accepted_last = 1'b1;
            end
        end
        cycle = cycle + 32'd1;
        if (cycle >= TIMEOUT_CYCLES) begin
            stop_with_failure("timeout: the operations did not drain within the cycle limit");
        end
    end

    initial begin
        clk = 1'b0;
        arst_n = 1'b0;
        in_valid = 1'b0;
        op_type = exec_pkg::OP_ALU;
        funct3 = '0;
        alt = 1'b0;
        rd = '0;
        rs1_value = '0;
        rs2_value = '0;
        store_value = '0;
        imm = '0;
        pc = '0;
        predicted_pc = '0;
        jump_base = '0;
        result_ready = 1'b0;
        mem_ready = 1'b0;
        jump_ready = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        wait (accepted_count == NUM_OPS);
        while (result_q.size() != 0 || mem_q.size() != 0 || jump_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (2) @(posedge clk);
        if (!result_valid && !mem_valid && !jump_valid) begin
            $display("TEST OK");
            $finish;
        end else begin
            stop_with_failure("an output stayed valid after every expected item was seen");
        end
    end

endmodule
